// ==== hdl/ntt_shuffle_buffer.sv ====
/*
 * NTT shuffle ping-pong buffer
 * Collects four rows into one half of a 2x4x4 coefficient store, flips
 * halves on every full block and returns one column of the other half
 */
module ntt_shuffle_buffer (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      in_valid,
    input  ntt_shuffle_pkg::row_t     in_row,
    input  ntt_shuffle_pkg::col_idx_t rd_col,
    output logic                      block_done,
    output ntt_shuffle_pkg::row_t     rd_data
);
    import ntt_shuffle_pkg::*;

    // two halves of four rows each, mem[half][row]
    row_t mem [2][NUM_LANES];

    // row counter inside the block being written
    col_idx_t row_cnt;

    // half that is currently written, the other one is readable
    logic wr_half;
    logic rd_half;

    // fourth row of a block is being taken this cycle
    logic last_row;

    assign last_row = in_valid && (row_cnt == col_idx_t'(NUM_LANES - 1));
    assign rd_half  = ~wr_half;

    // write side sequencing
    // the counter wraps by itself after row 3, and the same edge flips
    // the write half so the finished block becomes readable at once
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            row_cnt <= '0;
            wr_half <= 1'b0;
        end else if (zeroize) begin
            row_cnt <= '0;
            wr_half <= 1'b0;
        end else if (in_valid) begin
            row_cnt <= row_cnt + col_idx_t'(1);
            if (last_row) begin
                wr_half <= ~wr_half;
            end
        end
    end

    // block_done is one cycle behind the fourth row strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            block_done <= 1'b0;
        end else if (zeroize) begin
            block_done <= 1'b0;
        end else begin
            block_done <= last_row;
        end
    end

    // coefficient store
    // zeroize wipes both halves so nothing from an earlier key survives
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int h = 0; h < 2; h++) begin
                for (int r = 0; r < NUM_LANES; r++) begin
                    mem[h][r] <= '0;
                end
            end
        end else if (in_valid) begin
            mem[wr_half][row_cnt] <= in_row;
        end
    end

    // column read
    // lane r of the result is coefficient rd_col of row r, which turns
    // the stored rows into a column of the block
    always_comb begin
        rd_data = '0;
        for (int r = 0; r < NUM_LANES; r++) begin
            rd_data[r*COEFF_W +: COEFF_W] = mem[rd_half][r][rd_col*COEFF_W +: COEFF_W];
        end
    end

    // the row counter spaces blocks at least four cycles apart
    a_done_single: assert property (@(posedge clk) disable iff (!reset_n)
        block_done |=> !block_done)
        else $error("block_done held for more than one cycle");

    // zeroize restarts the row count, so no block can be announced
    // before four fresh rows have been written
    a_done_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize |=> !block_done [*4])
        else $error("block_done raised within four cycles of zeroize");

endmodule

// ==== hdl/ntt_shuffle_lfsr.sv ====
/*
 * NTT shuffle random source
 * Free-running 16-bit Galois LFSR whose low bits pick the start column
 * of a shuffled block
 */
module ntt_shuffle_lfsr (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    output ntt_shuffle_pkg::lfsr_t lfsr_rand
);
    import ntt_shuffle_pkg::*;

    lfsr_t state;
    lfsr_t state_nxt;

    // shift right, and when a one falls out of bit 0 fold it back
    // through the tap mask
    always_comb begin
        state_nxt = {1'b0, state[15:1]};
        if (state[0]) begin
            state_nxt = state_nxt ^ LFSR_TAPS;
        end
    end

    // steps on every clock, zeroize brings it back to the seed so that
    // the sequence restarts from a known point
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= LFSR_SEED;
        end else if (zeroize) begin
            state <= LFSR_SEED;
        end else begin
            state <= state_nxt;
        end
    end

    assign lfsr_rand = state;

    // a maximal-length sequence never passes through zero once seeded
    a_state_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
        state != '0)
        else $error("lfsr reached the all-zero lock-up state");

endmodule

// ==== hdl/ntt_shuffle_pkg.sv ====
/*
 * NTT shuffle stage package
 * Holds the coefficient, row and column types, the lane count, the LFSR
 * constants and the scheduler state encoding shared by the reorder stage
 */
package ntt_shuffle_pkg;

    // the lane count is fixed by the butterfly, four coefficients per row
    // and four rows per block
    localparam int NUM_LANES = 4;

    // width of one coefficient in bits
    localparam int COEFF_W = 24;

    // a single coefficient as it sits in memory
    typedef logic [COEFF_W-1:0] coeff_t;

    // one row of four coefficients, lane 0 in the low bits
    typedef logic [NUM_LANES*COEFF_W-1:0] row_t;

    // index of a column or a row inside a 4x4 block
    typedef logic [1:0] col_idx_t;

    // state of the random source
    typedef logic [15:0] lfsr_t;

    // nonzero starting value, an all-zero state would lock the LFSR
    localparam lfsr_t LFSR_SEED = 16'hACE1;

    // right-shifting Galois mask for taps 16, 14, 13 and 11
    localparam lfsr_t LFSR_TAPS = 16'hB400;

    // one output column together with the index it was read from
    // lane r of data holds the coefficient of row r in that column
    typedef struct packed {
        col_idx_t col;
        row_t     data;
    } col_out_t;

    // read scheduler states
    // idle waits for a finished block, busy walks the remaining columns
    typedef enum logic {
        RD_IDLE,
        RD_BUSY
    } rd_state_t;

endpackage

// ==== hdl/ntt_shuffle_rd_sched.sv ====
/*
 * NTT shuffle read scheduler
 * Walks the four columns of each finished block from an in-order or a
 * random start column and registers every column to the output
 */
module ntt_shuffle_rd_sched (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      shuffle_en,
    input  logic                      block_done,
    input  ntt_shuffle_pkg::lfsr_t    lfsr_rand,
    input  ntt_shuffle_pkg::row_t     rd_data,
    output ntt_shuffle_pkg::col_idx_t rd_col,
    output logic                      out_valid,
    output ntt_shuffle_pkg::col_out_t out_col
);
    import ntt_shuffle_pkg::*;

    rd_state_t state;

    // start column of the current walk and the offset from it
    col_idx_t start_q;
    col_idx_t step;

    // start column chosen in the block_done cycle
    col_idx_t start_sel;

    // a column is being read this cycle
    logic rd_active;

    assign start_sel = shuffle_en ? lfsr_rand[1:0] : '0;
    assign rd_active = block_done || (state == RD_BUSY);

    // the first column is read in the block_done cycle itself, the
    // remaining three follow from the latched start, wrapping modulo 4
    assign rd_col = block_done ? start_sel : col_idx_t'(start_q + step);

    // walk FSM
    // busy covers steps 1 to 3, the walk is over after step 3 so that a
    // block arriving on the very next cycle starts without a gap
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= RD_IDLE;
            start_q <= '0;
            step    <= '0;
        end else if (zeroize) begin
            state   <= RD_IDLE;
            start_q <= '0;
            step    <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (block_done) begin
                        state   <= RD_BUSY;
                        start_q <= start_sel;
                        step    <= col_idx_t'(1);
                    end
                end
                RD_BUSY: begin
                    step <= step + col_idx_t'(1);
                    if (step == col_idx_t'(NUM_LANES - 1)) begin
                        state <= RD_IDLE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // output strobe, one cycle after each column read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (zeroize) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_active;
        end
    end

    // output payload only moves on a read, out_valid qualifies it
    always_ff @(posedge clk) begin
        if (rd_active) begin
            out_col.col  <= rd_col;
            out_col.data <= rd_data;
        end
    end

    // a new block may only be announced once the last column of the
    // previous walk has been issued, otherwise the buffer half would be
    // overwritten under the read
    a_no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
        block_done |-> (state == RD_IDLE))
        else $error("block_done arrived while a column walk was in progress");

endmodule

// ==== hdl/ntt_shuffle_top.sv ====
/*
 * NTT shuffle reorder stage
 * Transposes incoming rows of four coefficients into columns, optionally
 * starting each block at a random column
 */
module ntt_shuffle_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      shuffle_en,
    input  logic                      in_valid,
    input  ntt_shuffle_pkg::row_t     in_row,
    output logic                      out_valid,
    output ntt_shuffle_pkg::col_out_t out_col
);
    import ntt_shuffle_pkg::*;

    // buffer to scheduler
    logic     block_done;
    row_t     rd_data;
    col_idx_t rd_col;

    // random source to scheduler
    lfsr_t    lfsr_rand;

    // store of two 4x4 blocks, written row by row
    ntt_shuffle_buffer buffer_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .in_valid   (in_valid),
        .in_row     (in_row),
        .rd_col     (rd_col),
        .block_done (block_done),
        .rd_data    (rd_data)
    );

    // runs freely, the scheduler samples it when a block completes
    ntt_shuffle_lfsr lfsr_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .lfsr_rand (lfsr_rand)
    );

    // column walk and output register
    ntt_shuffle_rd_sched rd_sched_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .shuffle_en (shuffle_en),
        .block_done (block_done),
        .lfsr_rand  (lfsr_rand),
        .rd_data    (rd_data),
        .rd_col     (rd_col),
        .out_valid  (out_valid),
        .out_col    (out_col)
    );

endmodule

// ==== sim/ntt_shuffle_tb.sv ====
/*
 * NTT shuffle reorder stage testbench
 * Streams random rows into the stage, keeps a queue of expected blocks
 * and checks every output column against the transpose of its block
 */
module ntt_shuffle_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ntt_shuffle_pkg::*;

    // a whole 4x4 block, row r at bits [r*96 +: 96]
    typedef logic [NUM_LANES*NUM_LANES*COEFF_W-1:0] block_t;

    logic      clk;
    logic      reset_n;
    logic      zeroize;
    logic      shuffle_en;
    logic      in_valid;
    row_t      in_row;
    logic      out_valid;
    col_out_t  out_col;

    // reference model state, owned by the monitor below
    block_t    exp_q[$];
    block_t    partial;
    block_t    head_blk;
    logic      have_block;
    col_idx_t  row_cnt;
    col_idx_t  col_cnt;
    col_idx_t  start_col;
    logic [3:0] starts_seen;
    string     test_name;

    ntt_shuffle_top ntt_shuffle_top_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .shuffle_en (shuffle_en),
        .in_valid   (in_valid),
        .in_row     (in_row),
        .out_valid  (out_valid),
        .out_col    (out_col)
    );

    always #20 clk = ~clk;

    // column c of a block has coefficient c of row r in lane r
    function automatic row_t column_of(input block_t blk, input col_idx_t c);
        row_t col;
        col = '0;
        for (int r = 0; r < NUM_LANES; r++) begin
            col[r*COEFF_W +: COEFF_W] = blk[r*NUM_LANES*COEFF_W + c*COEFF_W +: COEFF_W];
        end
        return col;
    endfunction

    task automatic report_mismatch(input string check, input logic [95:0] exp_v,
                                   input logic [95:0] act_v);
        $display("[ERROR] %s, %s: expected %h, actual %h", test_name, check, exp_v, act_v);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string why);
        $display("[ERROR] %s: %s", test_name, why);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    // monitor, it consumes output strobes first and then the input side,
    // so an output in the zeroize cycle still counts against its block
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exp_q.delete();
            partial = '0;
            row_cnt = '0;
            col_cnt = '0;
            start_col = '0;
        end else begin
            if (out_valid) begin
                if (col_cnt == '0) begin
                    start_col = out_col.col;
                    starts_seen[out_col.col] = 1'b1;
                end
                if (col_cnt == col_idx_t'(NUM_LANES - 1) && exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
                col_cnt = col_cnt + col_idx_t'(1);
            end
            if (zeroize) begin
                // a partial block and any pending walk are gone
                exp_q.delete();
                partial = '0;
                row_cnt = '0;
                col_cnt = '0;
            end else if (in_valid) begin
                partial[row_cnt*NUM_LANES*COEFF_W +: NUM_LANES*COEFF_W] = in_row;
                if (row_cnt == col_idx_t'(NUM_LANES - 1)) begin
                    exp_q.push_back(partial);
                end
                row_cnt = row_cnt + col_idx_t'(1);
            end
        end
        have_block = (exp_q.size() > 0);
        head_blk   = have_block ? exp_q[0] : '0;
    end

    // no column may appear without a complete block behind it
    a_expected: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> have_block)
        else report_failure("output column with no complete block pending");

    // transpose of the head block at the reported column
    a_data: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && have_block |-> out_col.data == column_of(head_blk, out_col.col))
        else report_mismatch("column data", column_of($sampled(head_blk),
                             $sampled(out_col.col)), $sampled(out_col.data));

    // in-order walk always starts at column 0
    a_first_col: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && col_cnt == '0 && !shuffle_en |-> out_col.col == '0)
        else report_mismatch("first column", 96'd0, 96'($sampled(out_col.col)));

    // later columns follow the start cyclically, modulo 4
    a_col_order: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && col_cnt != '0 |-> out_col.col == col_idx_t'(start_col + col_cnt))
        else report_mismatch("column order", 96'(col_idx_t'($sampled(start_col)
                             + $sampled(col_cnt))), 96'($sampled(out_col.col)));

    // four strobes in a row, starting two edges after the fourth row
    a_timing: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        in_valid && row_cnt == col_idx_t'(NUM_LANES - 1)
        |-> ##2 out_valid ##1 out_valid ##1 out_valid ##1 out_valid)
        else report_failure("block was not emitted on four consecutive cycles");

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // one row strobe, called and returning 2 ns after a rising edge
    task automatic drive_row(input row_t r);
        in_valid = 1'b1;
        in_row   = r;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // four random rows, each followed by up to max_gap idle cycles
    task automatic send_block(input int max_gap);
        for (int r = 0; r < NUM_LANES; r++) begin
            drive_row(row_t'({$urandom(), $urandom(), $urandom()}));
            if (max_gap > 0) begin
                idle_cycles($urandom % (max_gap + 1));
            end
        end
    endtask

    // every queued block has to come out before the limit runs out
    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 || out_valid) begin
            if (n >= limit) begin
                report_failure("timeout while waiting for pending blocks");
            end
            @(posedge clk);
            #2;
            n++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        zeroize     = 1'b0;
        shuffle_en  = 1'b0;
        in_valid    = 1'b0;
        in_row      = '0;
        starts_seen = '0;
        test_name   = "reset";
        void'($urandom(75));
        repeat (16) @(posedge clk);
        #2;
        reset_n = 1'b1;
        idle_cycles(2);

        test_name = "transpose";
        for (int b = 0; b < 8; b++) begin
            send_block(3);
        end
        wait_drained(200);

        // rows of a block back to back, gaps only between blocks
        test_name = "in_order_walk";
        for (int b = 0; b < 8; b++) begin
            send_block(0);
            idle_cycles($urandom % 6);
        end
        wait_drained(200);

        test_name   = "shuffled_walk";
        shuffle_en  = 1'b1;
        starts_seen = '0;
        for (int b = 0; b < 32; b++) begin
            send_block(2);
        end
        wait_drained(400);
        a_starts: assert ($countones(starts_seen) > 1)
            else report_failure("every shuffled block started at the same column");

        // a row on every cycle, blocks meet without a gap
        test_name = "back_to_back";
        for (int b = 0; b < 16; b++) begin
            send_block(0);
        end
        wait_drained(200);

        test_name  = "zeroize";
        shuffle_en = 1'b0;
        send_block(0);
        wait_drained(50);
        drive_row(row_t'({$urandom(), $urandom(), $urandom()}));
        drive_row(row_t'({$urandom(), $urandom(), $urandom()}));
        zeroize = 1'b1;
        idle_cycles(1);
        zeroize = 1'b0;
        // the dropped rows must not produce any strobe
        idle_cycles(10);
        send_block(1);
        wait_drained(50);
        send_block(0);
        wait_drained(50);
        idle_cycles(4);

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/ntt_shuffle_pkg.sv
hdl/ntt_shuffle_lfsr.sv
hdl/ntt_shuffle_buffer.sv
hdl/ntt_shuffle_rd_sched.sv
hdl/ntt_shuffle_top.sv
sim/ntt_shuffle_tb.sv
